//--- mem_test_config.svh
// bus widths and counter limits for the memory pattern test engine, pulled in with `include
`ifndef MEM_TEST_CONFIG_SVH
`define MEM_TEST_CONFIG_SVH

// ==========================================================================
// bus widths
// ==========================================================================

// byte address carried on both request channels
`define MT_ADDR_W 32

// one data word, which is also the width of a pattern
`define MT_DATA_W 32

// ==========================================================================
// counter limits
// ==========================================================================

// transaction, loop and set counts all share this width, so 255 is the most
// that any one of them can hold
`define MT_CNT_W 8

`endif

//--- mem_test_pkg.sv
// shared vector types and the sequencer state encoding, referenced by scoped name from the RTL
`include "mem_test_config.svh"

package mem_test_pkg;

  // ========================================================================
  // vector types
  // ========================================================================

  typedef logic [`MT_ADDR_W-1:0] addr_t;  // byte address on the host bus
  typedef logic [`MT_DATA_W-1:0] data_t;  // pattern word or data word
  typedef logic [`MT_CNT_W-1:0]  cnt_t;   // transaction index, loop or set count

  // ========================================================================
  // sequencer states
  // ========================================================================

  // WRITE and READ each cover one whole phase, from the start pulse to the
  // last response, and NEXT decides whether another set follows
  typedef enum logic [2:0]
  {
    IDLE  = 3'd0,  // waiting for a start pulse
    WRITE = 3'd1,  // write phase of the current set
    READ  = 3'd2,  // self-checking read phase of the current set
    NEXT  = 3'd3,  // step set and loop counts, or finish
    DONE  = 3'd4   // one cycle that carries the done pulse
  } seq_state_t;

endpackage

//--- mem_test_seq_fsm.sv
// sequencing FSM that walks loops and sets and starts each write and read phase of a run
`timescale 1ns/1ps

module mem_test_seq_fsm
(
  input  logic                       clk,
  input  logic                       i_rst_n,
  input  logic                       i_start,         // one cycle pulse, taken only in IDLE
  input  logic                       i_self_check,    // adds a read phase after every write
  input  mem_test_pkg::addr_t        i_base_addr,
  input  mem_test_pkg::addr_t        i_set_offset,
  input  mem_test_pkg::data_t        i_base_pattern,
  input  mem_test_pkg::cnt_t         i_num_sets,
  input  mem_test_pkg::cnt_t         i_num_loops,
  input  logic                       i_phase_done,    // last response of the phase has landed
  input  logic                       i_err_found,     // sticky mismatch flag from the checker
  output logic                       o_wr_phase_start,
  output logic                       o_rd_phase_start,
  output logic                       o_clear_err,
  output mem_test_pkg::addr_t        o_cur_x,         // base address X of the current set
  output mem_test_pkg::data_t        o_cur_p,         // pattern P of the current loop
  output logic                       o_busy,
  output logic                       o_done
);

  mem_test_pkg::seq_state_t state;
  mem_test_pkg::cnt_t       loop_cnt;  // loop L, which also offsets the pattern
  mem_test_pkg::cnt_t       set_cnt;   // set S within the current loop
  logic                     last_set;
  logic                     last_loop;

  assign last_set  = (set_cnt == i_num_sets - 1'b1);
  assign last_loop = (loop_cnt == i_num_loops - 1'b1);

  // busy covers every state but IDLE, so it drops on the edge that ends DONE
  // and the done pulse always sits inside the busy window
  assign o_busy = (state != mem_test_pkg::IDLE);
  assign o_done = (state == mem_test_pkg::DONE);

  // ==========================================================================
  // state and count register
  // ==========================================================================
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      state            <= mem_test_pkg::IDLE;
      loop_cnt         <= '0;
      set_cnt          <= '0;
      o_wr_phase_start <= 1'b0;
      o_rd_phase_start <= 1'b0;
      o_clear_err      <= 1'b0;
    end
    else
    begin
      o_wr_phase_start <= 1'b0;  // the phase starts and the clear are one cycle pulses
      o_rd_phase_start <= 1'b0;
      o_clear_err      <= 1'b0;
      case (state)
        mem_test_pkg::IDLE:
        begin
          if (i_start)
          begin
            state            <= mem_test_pkg::WRITE;
            loop_cnt         <= '0;
            set_cnt          <= '0;
            o_wr_phase_start <= 1'b1;
            o_clear_err      <= 1'b1;  // the error record of the last run goes away here
          end
        end
        mem_test_pkg::WRITE:
        begin
          if (i_phase_done && i_self_check)
          begin
            state            <= mem_test_pkg::READ;
            o_rd_phase_start <= 1'b1;
          end
          else if (i_phase_done)
            state <= mem_test_pkg::NEXT;  // writes only, skip the read back
        end
        mem_test_pkg::READ:
        begin
          if (i_phase_done)
            state <= mem_test_pkg::NEXT;
        end
        mem_test_pkg::NEXT:
        begin
          // a mismatch ends the run here, at the end of the set that found it
          if (i_err_found || (last_set && last_loop))
            state <= mem_test_pkg::DONE;
          else
          begin
            state            <= mem_test_pkg::WRITE;
            o_wr_phase_start <= 1'b1;
            if (last_set)
            begin
              set_cnt  <= '0;
              loop_cnt <= loop_cnt + 1'b1;
            end
            else
              set_cnt <= set_cnt + 1'b1;
          end
        end
        mem_test_pkg::DONE: state <= mem_test_pkg::IDLE;
        default:            state <= mem_test_pkg::IDLE;
      endcase
    end
  end

  // ==========================================================================
  // set base X and pattern P
  // ==========================================================================
  // X and P follow the counts by addition so that no multiplier is needed
  always_ff @(posedge clk)
  begin
    if (state == mem_test_pkg::IDLE && i_start)
    begin
      o_cur_x <= i_base_addr;
      o_cur_p <= i_base_pattern;
    end
    else if (state == mem_test_pkg::NEXT && !last_set)
      o_cur_x <= o_cur_x + i_set_offset;  // next set in the same loop
    else if (state == mem_test_pkg::NEXT)
    begin
      o_cur_x <= i_base_addr;             // new loop starts again from the first set
      o_cur_p <= o_cur_p + 1'b1;          // and every loop bumps the pattern by one
    end
  end

endmodule

//--- mem_test_txn_counter.sv
// request and response counter shared by the write and read phases, telling them when they are done
`timescale 1ns/1ps

module mem_test_txn_counter
(
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_phase_start,  // clears both counts for a new phase
  input  mem_test_pkg::cnt_t i_num_txn,      // words in one set
  input  logic               i_wr_fire,      // write request transferred
  input  logic               i_rd_fire,      // read request transferred
  input  logic               i_wr_resp,      // write response strobe
  input  logic               i_rd_resp,      // read response strobe
  output mem_test_pkg::cnt_t o_issue_idx,    // index of the next request to issue
  output mem_test_pkg::cnt_t o_resp_idx,     // index of the next response expected
  output logic               o_issue_done,
  output logic               o_phase_done
);

  logic active;  // a phase is running and its done flag may rise

  // only one phase runs at a time, so one pair of counts serves both channels
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      o_issue_idx <= '0;
      o_resp_idx  <= '0;
      active      <= 1'b0;
    end
    else if (i_phase_start)
    begin
      o_issue_idx <= '0;
      o_resp_idx  <= '0;
      active      <= 1'b1;
    end
    else
    begin
      if (i_wr_fire || i_rd_fire)
        o_issue_idx <= o_issue_idx + 1'b1;  // holds still while the channel is stalled
      if (i_wr_resp || i_rd_resp)
        o_resp_idx <= o_resp_idx + 1'b1;
      if (o_phase_done)
        active <= 1'b0;                     // done shows for one cycle only
    end
  end

  // the counts stay at the limit between phases, which keeps both issuers quiet
  assign o_issue_done = (o_issue_idx == i_num_txn);

  // rises on the cycle after the last response strobe
  assign o_phase_done = active && (o_resp_idx == i_num_txn);

endmodule

//--- mem_test_write_issue.sv
// write request issuer that walks the set addresses and drives P plus n as the data word
`timescale 1ns/1ps

module mem_test_write_issue
(
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_phase_start,  // write phase begins
  input  mem_test_pkg::cnt_t  i_issue_idx,    // transaction n of the pending request
  input  logic                i_issue_done,   // every write of the set has transferred
  input  mem_test_pkg::addr_t i_cur_x,
  input  mem_test_pkg::data_t i_cur_p,
  input  mem_test_pkg::addr_t i_addr_inc,
  input  logic                i_wr_ready,
  output logic                o_wr_valid,
  output mem_test_pkg::addr_t o_wr_addr,
  output mem_test_pkg::data_t o_wr_data,
  output logic                o_wr_fire       // request transfers this cycle
);

  logic                run;       // write phase owns the request channel
  mem_test_pkg::addr_t addr_acc;  // X plus n times the increment, built by addition

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      run <= 1'b0;
    else if (i_phase_start)
      run <= 1'b1;
    else if (i_issue_done)
      run <= 1'b0;  // stale done from the last phase is masked by the start above
  end

  // address moves only on a transfer, so it holds while ready is low
  always_ff @(posedge clk)
  begin
    if (i_phase_start)
      addr_acc <= i_cur_x;
    else if (o_wr_fire)
      addr_acc <= addr_acc + i_addr_inc;
  end

  assign o_wr_valid = run && !i_issue_done;
  assign o_wr_addr  = addr_acc;
  assign o_wr_data  = i_cur_p + mem_test_pkg::data_t'(i_issue_idx);  // index only steps on fire
  assign o_wr_fire  = o_wr_valid && i_wr_ready;

endmodule

//--- mem_test_read_check.sv
// read request issuer and response checker that records the first data mismatch of a run
`timescale 1ns/1ps

module mem_test_read_check
(
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_phase_start,   // read phase begins
  input  logic                i_clear_err,     // new run, forget the old error
  input  mem_test_pkg::cnt_t  i_issue_idx,
  input  logic                i_issue_done,
  input  mem_test_pkg::cnt_t  i_resp_idx,      // transaction n of the arriving response
  input  mem_test_pkg::addr_t i_cur_x,
  input  mem_test_pkg::data_t i_cur_p,
  input  mem_test_pkg::addr_t i_addr_inc,
  input  logic                i_rd_ready,
  input  logic                i_rd_resp,
  input  mem_test_pkg::data_t i_rd_data,
  output logic                o_rd_valid,
  output mem_test_pkg::addr_t o_rd_addr,
  output logic                o_rd_fire,
  output logic                o_err_found,     // sticky until the next start
  output mem_test_pkg::addr_t o_err_addr,
  output mem_test_pkg::data_t o_err_expected,
  output mem_test_pkg::data_t o_err_received
);

  logic                run;       // read phase owns the request channel
  mem_test_pkg::addr_t req_addr;  // address of the pending read request
  mem_test_pkg::addr_t rsp_addr;  // address that the arriving response belongs to
  mem_test_pkg::data_t expected;
  logic                mismatch;

  // ==========================================================================
  // request side
  // ==========================================================================
  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      run <= 1'b0;
    else if (i_phase_start)
      run <= 1'b1;
    else if (i_issue_done)
      run <= 1'b0;
  end

  // responses come back in request order, so a second accumulator that steps
  // on each strobe tracks the address of every response
  always_ff @(posedge clk)
  begin
    if (i_phase_start)
    begin
      req_addr <= i_cur_x;
      rsp_addr <= i_cur_x;
    end
    else
    begin
      if (o_rd_fire)
        req_addr <= req_addr + i_addr_inc;  // stable under stall
      if (i_rd_resp)
        rsp_addr <= rsp_addr + i_addr_inc;
    end
  end

  assign o_rd_valid = run && !i_issue_done;
  assign o_rd_addr  = req_addr;
  assign o_rd_fire  = o_rd_valid && i_rd_ready;

  // ==========================================================================
  // response side
  // ==========================================================================
  assign expected = i_cur_p + mem_test_pkg::data_t'(i_resp_idx);  // P plus n
  assign mismatch = i_rd_resp && (i_rd_data != expected);

  always_ff @(posedge clk)
  begin
    if (!i_rst_n)
      o_err_found <= 1'b0;
    else if (i_clear_err)
      o_err_found <= 1'b0;
    else if (mismatch)
      o_err_found <= 1'b1;
  end

  // only the first mismatch is kept, later ones leave the record alone
  always_ff @(posedge clk)
  begin
    if (i_clear_err)
    begin
      o_err_addr     <= '0;
      o_err_expected <= '0;
      o_err_received <= '0;
    end
    else if (mismatch && !o_err_found)
    begin
      o_err_addr     <= rsp_addr;
      o_err_expected <= expected;
      o_err_received <= i_rd_data;
    end
  end

endmodule

//--- mem_test_top.sv
// top level of the memory pattern test engine that wires the sequencer, counter and both channels
`timescale 1ns/1ps

module mem_test_top
(
  input  logic                clk,
  input  logic                i_rst_n,
  // control
  input  logic                i_start,
  input  logic                i_self_check,
  output logic                o_busy,
  output logic                o_done,
  output logic                o_error_found,
  // configuration, held stable while busy
  input  mem_test_pkg::addr_t i_base_addr,
  input  mem_test_pkg::addr_t i_addr_inc,
  input  mem_test_pkg::addr_t i_set_offset,
  input  mem_test_pkg::data_t i_base_pattern,
  input  mem_test_pkg::cnt_t  i_num_txn,
  input  mem_test_pkg::cnt_t  i_num_sets,
  input  mem_test_pkg::cnt_t  i_num_loops,
  // write request channel and its response strobe
  output logic                o_wr_valid,
  output mem_test_pkg::addr_t o_wr_addr,
  output mem_test_pkg::data_t o_wr_data,
  input  logic                i_wr_ready,
  input  logic                i_wr_resp,
  // read request channel and its response strobe
  output logic                o_rd_valid,
  output mem_test_pkg::addr_t o_rd_addr,
  input  logic                i_rd_ready,
  input  logic                i_rd_resp,
  input  mem_test_pkg::data_t i_rd_data,
  // first mismatch of the run
  output mem_test_pkg::addr_t o_err_addr,
  output mem_test_pkg::data_t o_err_expected,
  output mem_test_pkg::data_t o_err_received
);

  // ==========================================================================
  // wires between the blocks
  // ==========================================================================
  logic                wr_phase_start;
  logic                rd_phase_start;
  logic                clear_err;
  mem_test_pkg::addr_t cur_x;
  mem_test_pkg::data_t cur_p;
  mem_test_pkg::cnt_t  issue_idx;
  mem_test_pkg::cnt_t  resp_idx;
  logic                issue_done;
  logic                phase_done;
  logic                wr_fire;
  logic                rd_fire;

  mem_test_seq_fsm u_seq_fsm
  (
    .clk              ( clk            ),
    .i_rst_n          ( i_rst_n        ),
    .i_start          ( i_start        ),
    .i_self_check     ( i_self_check   ),
    .i_base_addr      ( i_base_addr    ),
    .i_set_offset     ( i_set_offset   ),
    .i_base_pattern   ( i_base_pattern ),
    .i_num_sets       ( i_num_sets     ),
    .i_num_loops      ( i_num_loops    ),
    .i_phase_done     ( phase_done     ),
    .i_err_found      ( o_error_found  ),  // stops the run after the current set
    .o_wr_phase_start ( wr_phase_start ),
    .o_rd_phase_start ( rd_phase_start ),
    .o_clear_err      ( clear_err      ),
    .o_cur_x          ( cur_x          ),
    .o_cur_p          ( cur_p          ),
    .o_busy           ( o_busy         ),
    .o_done           ( o_done         )
  );

  // either phase start restarts the shared counts
  mem_test_txn_counter u_txn_counter
  (
    .clk           ( clk                             ),
    .i_rst_n       ( i_rst_n                         ),
    .i_phase_start ( wr_phase_start || rd_phase_start ),
    .i_num_txn     ( i_num_txn                       ),
    .i_wr_fire     ( wr_fire                         ),
    .i_rd_fire     ( rd_fire                         ),
    .i_wr_resp     ( i_wr_resp                       ),
    .i_rd_resp     ( i_rd_resp                       ),
    .o_issue_idx   ( issue_idx                       ),
    .o_resp_idx    ( resp_idx                        ),
    .o_issue_done  ( issue_done                      ),
    .o_phase_done  ( phase_done                      )
  );

  mem_test_write_issue u_write_issue
  (
    .clk           ( clk            ),
    .i_rst_n       ( i_rst_n        ),
    .i_phase_start ( wr_phase_start ),
    .i_issue_idx   ( issue_idx      ),
    .i_issue_done  ( issue_done     ),
    .i_cur_x       ( cur_x          ),
    .i_cur_p       ( cur_p          ),
    .i_addr_inc    ( i_addr_inc     ),
    .i_wr_ready    ( i_wr_ready     ),
    .o_wr_valid    ( o_wr_valid     ),
    .o_wr_addr     ( o_wr_addr      ),
    .o_wr_data     ( o_wr_data      ),
    .o_wr_fire     ( wr_fire        )
  );

  mem_test_read_check u_read_check
  (
    .clk            ( clk            ),
    .i_rst_n        ( i_rst_n        ),
    .i_phase_start  ( rd_phase_start ),
    .i_clear_err    ( clear_err      ),
    .i_issue_idx    ( issue_idx      ),
    .i_issue_done   ( issue_done     ),
    .i_resp_idx     ( resp_idx       ),
    .i_cur_x        ( cur_x          ),
    .i_cur_p        ( cur_p          ),
    .i_addr_inc     ( i_addr_inc     ),
    .i_rd_ready     ( i_rd_ready     ),
    .i_rd_resp      ( i_rd_resp      ),
    .i_rd_data      ( i_rd_data      ),
    .o_rd_valid     ( o_rd_valid     ),
    .o_rd_addr      ( o_rd_addr      ),
    .o_rd_fire      ( rd_fire        ),
    .o_err_found    ( o_error_found  ),
    .o_err_addr     ( o_err_addr     ),
    .o_err_expected ( o_err_expected ),
    .o_err_received ( o_err_received )
  );

endmodule

//--- mem_test_chk.sv
// checker bound into the engine top level, holding concurrent assertions on its ports
`timescale 1ns/1ps

module mem_test_chk
(
  input logic                clk,
  input logic                i_rst_n,
  input logic                i_busy,
  input logic                i_done,
  input logic                i_error_found,
  input logic                i_wr_valid,
  input mem_test_pkg::addr_t i_wr_addr,
  input mem_test_pkg::data_t i_wr_data,
  input logic                i_wr_ready,
  input logic                i_rd_valid,
  input mem_test_pkg::addr_t i_rd_addr,
  input logic                i_rd_ready
);

  int unsigned reset_fails    = 0;  // one tally per assertion
  int unsigned wr_stall_fails = 0;
  int unsigned rd_stall_fails = 0;
  int unsigned done_fails     = 0;
  int unsigned pulse_fails    = 0;
  int unsigned total_fails;

  assign total_fails = reset_fails + wr_stall_fails + rd_stall_fails + done_fails + pulse_fails;

  // ==========================================================================
  // reset and handshake
  // ==========================================================================
  // a reset cycle leaves every control output low on the cycle after
  a_reset_state: assert property (@(posedge clk)
    !i_rst_n |=> !i_busy && !i_done && !i_wr_valid && !i_rd_valid && !i_error_found)
  else
  begin
    reset_fails++;
    $error("control outputs not low after reset");
  end

  a_wr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wr_valid && !i_wr_ready |=> i_wr_valid && $stable(i_wr_addr) && $stable(i_wr_data))
  else
  begin
    wr_stall_fails++;
    $error("write request dropped or changed while stalled");
  end

  a_rd_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_rd_valid && !i_rd_ready |=> i_rd_valid && $stable(i_rd_addr))
  else
  begin
    rd_stall_fails++;
    $error("read request dropped or changed while stalled");
  end

  // ==========================================================================
  // done pulse
  // ==========================================================================
  a_done_busy: assert property (@(posedge clk) disable iff (!i_rst_n) i_done |-> i_busy)
  else
  begin
    done_fails++;
    $error("done raised while not busy");
  end

  // done lasts one cycle and busy drops with it
  a_done_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_done |=> !i_done && !i_busy)
  else
  begin
    pulse_fails++;
    $error("done longer than one cycle or busy still high after it");
  end

endmodule

//--- tb_mem_test.sv
// testbench for the memory pattern test engine, with a stalling memory model and result lines
`timescale 1ns/1ps
`include "mem_test_config.svh"

module tb_mem_test;

  localparam int RUN_LIMIT = 4000;  // cycles one run may take before it counts as hung

  // ==========================================================================
  // run configuration shared by every test
  // ==========================================================================
  localparam mem_test_pkg::addr_t BASE_ADDR  = 32'h0000_1000;
  localparam mem_test_pkg::addr_t ADDR_INC   = 32'h0000_0004;
  localparam mem_test_pkg::addr_t SET_OFFSET = 32'h0000_0100;  // wide enough that sets never overlap
  localparam mem_test_pkg::data_t BASE_PAT   = 32'hA5A5_0000;
  localparam mem_test_pkg::cnt_t  NUM_TXN    = 8'd4;
  localparam mem_test_pkg::cnt_t  NUM_SETS   = 8'd3;
  localparam mem_test_pkg::addr_t FLIP_ADDR  = BASE_ADDR + 32'd2 * ADDR_INC;  // word 2 of set 0
  localparam int                  FLIP_BIT   = 5;

  logic                clk;
  logic                i_rst_n;
  logic                i_start;
  logic                i_self_check;
  logic                o_busy;
  logic                o_done;
  logic                o_error_found;
  mem_test_pkg::addr_t i_base_addr;
  mem_test_pkg::addr_t i_addr_inc;
  mem_test_pkg::addr_t i_set_offset;
  mem_test_pkg::data_t i_base_pattern;
  mem_test_pkg::cnt_t  i_num_txn;
  mem_test_pkg::cnt_t  i_num_sets;
  mem_test_pkg::cnt_t  i_num_loops;
  logic                o_wr_valid;
  mem_test_pkg::addr_t o_wr_addr;
  mem_test_pkg::data_t o_wr_data;
  logic                i_wr_ready = 1'b0;  // memory model side starts quiet
  logic                i_wr_resp  = 1'b0;
  logic                o_rd_valid;
  mem_test_pkg::addr_t o_rd_addr;
  logic                i_rd_ready = 1'b0;
  logic                i_rd_resp  = 1'b0;
  mem_test_pkg::data_t i_rd_data  = '0;
  mem_test_pkg::addr_t o_err_addr;
  mem_test_pkg::data_t o_err_expected;
  mem_test_pkg::data_t o_err_received;

  // memory model state
  mem_test_pkg::data_t mem [mem_test_pkg::addr_t];  // sparse so that only written words exist
  mem_test_pkg::data_t rd_q [$];                    // read data waiting for its strobe
  int unsigned         wr_pend    = 0;              // write responses still owed
  int unsigned         wr_count   = 0;              // write transfers since time zero
  int unsigned         rd_count   = 0;
  integer              seed       = 32'h199c;
  logic                flip_armed = 1'b0;           // corrupt FLIP_ADDR right after it is written
  int                  errors     = 0;

  mem_test_top DUT
  (
    .clk            ( clk            ),
    .i_rst_n        ( i_rst_n        ),
    .i_start        ( i_start        ),
    .i_self_check   ( i_self_check   ),
    .o_busy         ( o_busy         ),
    .o_done         ( o_done         ),
    .o_error_found  ( o_error_found  ),
    .i_base_addr    ( i_base_addr    ),
    .i_addr_inc     ( i_addr_inc     ),
    .i_set_offset   ( i_set_offset   ),
    .i_base_pattern ( i_base_pattern ),
    .i_num_txn      ( i_num_txn      ),
    .i_num_sets     ( i_num_sets     ),
    .i_num_loops    ( i_num_loops    ),
    .o_wr_valid     ( o_wr_valid     ),
    .o_wr_addr      ( o_wr_addr      ),
    .o_wr_data      ( o_wr_data      ),
    .i_wr_ready     ( i_wr_ready     ),
    .i_wr_resp      ( i_wr_resp      ),
    .o_rd_valid     ( o_rd_valid     ),
    .o_rd_addr      ( o_rd_addr      ),
    .i_rd_ready     ( i_rd_ready     ),
    .i_rd_resp      ( i_rd_resp      ),
    .i_rd_data      ( i_rd_data      ),
    .o_err_addr     ( o_err_addr     ),
    .o_err_expected ( o_err_expected ),
    .o_err_received ( o_err_received )
  );

  bind mem_test_top mem_test_chk u_chk
  (
    .clk           ( clk           ),
    .i_rst_n       ( i_rst_n       ),
    .i_busy        ( o_busy        ),
    .i_done        ( o_done        ),
    .i_error_found ( o_error_found ),
    .i_wr_valid    ( o_wr_valid    ),
    .i_wr_addr     ( o_wr_addr     ),
    .i_wr_data     ( o_wr_data     ),
    .i_wr_ready    ( i_wr_ready    ),
    .i_rd_valid    ( o_rd_valid    ),
    .i_rd_addr     ( o_rd_addr     ),
    .i_rd_ready    ( i_rd_ready    )
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ==========================================================================
  // memory model with random stalls and in-order delayed responses
  // ==========================================================================
  task automatic flip_stored_bit(input mem_test_pkg::addr_t addr, input int bit_idx);
    mem[addr] = mem[addr] ^ (32'h1 << bit_idx);
  endtask

  always @(posedge clk)
  begin
    if (!i_rst_n)
    begin
      i_wr_ready <= 1'b0;
      i_rd_ready <= 1'b0;
      i_wr_resp  <= 1'b0;
      i_rd_resp  <= 1'b0;
    end
    else
    begin
      if (o_wr_valid && i_wr_ready)  // transfer in the cycle that just ended
      begin
        mem[o_wr_addr] = o_wr_data;
        if (flip_armed && o_wr_addr == FLIP_ADDR)
          flip_stored_bit(o_wr_addr, FLIP_BIT);
        wr_pend  = wr_pend + 1;
        wr_count = wr_count + 1;
      end
      if (o_rd_valid && i_rd_ready)
      begin
        rd_q.push_back(mem.exists(o_rd_addr) ? mem[o_rd_addr] : '0);  // data taken at request
        rd_count = rd_count + 1;
      end
      i_wr_ready <= (($random(seed) & 3) != 0);  // stall about one cycle in four
      i_rd_ready <= (($random(seed) & 3) != 0);
      // each owed response goes out with even odds per cycle, which gives a random delay
      if (wr_pend > 0 && ($random(seed) & 1) != 0)
      begin
        i_wr_resp <= 1'b1;
        wr_pend = wr_pend - 1;
      end
      else
        i_wr_resp <= 1'b0;
      if (rd_q.size() > 0 && ($random(seed) & 1) != 0)
      begin
        i_rd_resp <= 1'b1;
        i_rd_data <= rd_q.pop_front();
      end
      else
        i_rd_resp <= 1'b0;
    end
  end

  // ==========================================================================
  // test helpers
  // ==========================================================================
  task automatic check_value(input string name, input logic [`MT_DATA_W-1:0] got,
                             input logic [`MT_DATA_W-1:0] exp);
    assert (got == exp)
    else
    begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // every word of every set must hold pattern plus n
  task automatic check_set_contents(input mem_test_pkg::data_t pattern);
    int                  s;
    int                  n;
    mem_test_pkg::addr_t addr;
    for (s = 0; s < NUM_SETS; s++)
      for (n = 0; n < NUM_TXN; n++)
      begin
        addr = BASE_ADDR + 32'(s) * SET_OFFSET + 32'(n) * ADDR_INC;
        check_value($sformatf("mem[%h]", addr), mem.exists(addr) ? mem[addr] : '0,
                    pattern + 32'(n));
      end
  endtask

  // stale contents that the run has to overwrite before reading back
  task automatic preload_stale(input mem_test_pkg::data_t pattern);
    int                  s;
    int                  n;
    mem_test_pkg::addr_t addr;
    for (s = 0; s < NUM_SETS; s++)
      for (n = 0; n < NUM_TXN; n++)
      begin
        addr      = BASE_ADDR + 32'(s) * SET_OFFSET + 32'(n) * ADDR_INC;
        mem[addr] = ~(pattern + 32'(n));
      end
  endtask

  task automatic run_engine(input logic self_check, input mem_test_pkg::cnt_t loops);
    int cyc;
    bit seen;
    @(posedge clk);
    i_self_check <= self_check;
    i_num_loops  <= loops;
    i_start      <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
    seen = 1'b0;
    for (cyc = 0; cyc < RUN_LIMIT && !seen; cyc++)
    begin
      @(posedge clk);
      seen = o_done;  // o_done comes from the state register and settled before this edge
    end
    if (!seen)
    begin
      $display("engine never raised done within %0d cycles, stopped waiting at %0t",
               RUN_LIMIT, $time);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int failed);
    $display("test %-16s finished with %0d errors", name, failed);
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial
  begin
    int          err_before;
    int unsigned wr_base;
    int unsigned rd_base;
    int unsigned chk_fails;
    i_rst_n        <= 1'b0;
    i_start        <= 1'b0;
    i_self_check   <= 1'b0;
    i_base_addr    <= BASE_ADDR;
    i_addr_inc     <= ADDR_INC;
    i_set_offset   <= SET_OFFSET;
    i_base_pattern <= BASE_PAT;
    i_num_txn      <= NUM_TXN;
    i_num_sets     <= NUM_SETS;
    i_num_loops    <= 8'd2;
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;
    @(posedge clk);
    report_test("reset_state", int'(DUT.u_chk.reset_fails));

    // writes only over 2 loops of 3 sets so the second loop's pattern is left behind
    err_before = errors;
    wr_base    = wr_count;
    rd_base    = rd_count;
    run_engine(1'b0, 8'd2);
    check_set_contents(BASE_PAT + 32'd1);
    check_value("write requests", wr_count - wr_base, 32'd24);
    check_value("read requests", rd_count - rd_base, 32'd0);
    report_test("write_contents", errors - err_before);

    err_before = errors;
    wr_base    = wr_count;
    rd_base    = rd_count;
    run_engine(1'b1, 8'd2);
    check_value("o_error_found", 32'(o_error_found), 32'd0);
    check_value("write requests", wr_count - wr_base, 32'd24);
    check_value("read requests", rd_count - rd_base, 32'd24);
    report_test("clean_selfcheck", errors - err_before);

    // one loop where word 2 of set 0 gets bit 5 flipped as it is written
    err_before = errors;
    preload_stale(BASE_PAT);
    flip_armed = 1'b1;
    wr_base    = wr_count;
    rd_base    = rd_count;
    run_engine(1'b1, 8'd1);
    flip_armed = 1'b0;
    check_value("o_error_found", 32'(o_error_found), 32'd1);
    check_value("o_err_addr", o_err_addr, FLIP_ADDR);
    check_value("o_err_expected", o_err_expected, BASE_PAT + 32'd2);
    check_value("o_err_received", o_err_received, (BASE_PAT + 32'd2) ^ (32'h1 << FLIP_BIT));
    check_value("write requests", wr_count - wr_base, 32'(NUM_TXN));  // stopped after set 0
    check_value("read requests", rd_count - rd_base, 32'(NUM_TXN));
    report_test("error_capture", errors - err_before);

    repeat (4) @(posedge clk);
    chk_fails = DUT.u_chk.total_fails;
    report_test("stall_and_done", int'(chk_fails));
    $display("checks failed %0d, assertion failures %0d", errors, chk_fails);
    if (errors == 0 && chk_fails == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
mem_test_pkg.sv
mem_test_seq_fsm.sv
mem_test_txn_counter.sv
mem_test_write_issue.sv
mem_test_read_check.sv
mem_test_top.sv
mem_test_chk.sv
tb_mem_test.sv

//--- Makefile
# Verilator build and run for the memory pattern test engine testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_test
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, a missing pass line counts as a failure too
run: compile
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
